/* hw/attn_pkg.sv */
package attn_pkg;

    ////////////////////////////////////////
    // element and tile geometry
    ////////////////////////////////////////
    localparam int D_W    = 16;                // bits per matrix element
    localparam int TILE_N = 4;                 // square tile edge

    typedef logic [D_W-1:0] elem_t;            // unsigned, wraps mod 2^16

    // indexed [row][col]
    typedef elem_t [TILE_N-1:0][TILE_N-1:0] tile_t;

    typedef logic [5:0] row_idx_t;             // up to 64 tile rows
    typedef logic [2:0] col_idx_t;             // up to 8 depth blocks

    ////////////////////////////////////////
    // memory target selector
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        KIND_Q = 2'd0,
        KIND_K = 2'd1,
        KIND_V = 2'd2,
        KIND_O = 2'd3
    } tile_kind_e;

endpackage

/* hw/attn_ifs.sv */
`timescale 1ns/100ps

// tile memory bus, req is held until the rvld pulse
interface tile_mem_if;
    import attn_pkg::*;

    logic       req;
    logic       we;
    tile_kind_e kind;
    row_idx_t   row;
    col_idx_t   col;
    tile_t      wdata;
    tile_t      rdata;
    logic       rvld;

    modport requester (output req, we, kind, row, col, wdata,
                       input  rdata, rvld);
    modport arbiter   (input  req, we, kind, row, col, wdata,
                       output rdata, rvld);
endinterface

// operand request from the sequencer to the fetcher
interface fetch_if;
    import attn_pkg::*;

    logic       fetch;                         // one-cycle command
    tile_kind_e kind;
    row_idx_t   row;
    col_idx_t   col;
    tile_t      tile;                          // K comes back transposed
    logic       ready;                         // one-cycle answer

    modport ctrl    (output fetch, kind, row, col, input  tile, ready);
    modport fetcher (input  fetch, kind, row, col, output tile, ready);
endinterface

// result tile handed to the O accumulator
interface accum_if;
    import attn_pkg::*;

    logic     post;
    row_idx_t row;
    col_idx_t col;
    tile_t    tile;
    logic     busy;

    modport ctrl  (output post, row, col, tile, input  busy);
    modport accum (input  post, row, col, tile, output busy);
endinterface

/* hw/tile_arbiter.sv */
`timescale 1ns/100ps

module tile_arbiter (
    input  logic                 I_CLK,
    input  logic                 I_RST_N,
    tile_mem_if.arbiter          fetch_bus,
    tile_mem_if.arbiter          accum_bus,
    output logic                 mem_req,
    output logic                 mem_we,
    output attn_pkg::tile_kind_e mem_kind,
    output attn_pkg::row_idx_t   mem_row,
    output attn_pkg::col_idx_t   mem_col,
    output attn_pkg::tile_t      mem_wdata,
    input  attn_pkg::tile_t      mem_rdata,
    input  logic                 mem_rvld
);

    logic locked;                              // a transaction owns the bus
    logic owner_accum;                         // owner while locked
    logic sel_accum;

    // fetcher wins when both ask in the same cycle
    assign sel_accum = locked ? owner_accum : !fetch_bus.req;

    assign mem_req   = sel_accum ? accum_bus.req   : fetch_bus.req;
    assign mem_we    = sel_accum ? accum_bus.we    : fetch_bus.we;
    assign mem_kind  = sel_accum ? accum_bus.kind  : fetch_bus.kind;
    assign mem_row   = sel_accum ? accum_bus.row   : fetch_bus.row;
    assign mem_col   = sel_accum ? accum_bus.col   : fetch_bus.col;
    assign mem_wdata = sel_accum ? accum_bus.wdata : fetch_bus.wdata;

    // response goes back to the granted side only
    assign fetch_bus.rvld  = mem_rvld && !sel_accum;
    assign accum_bus.rvld  = mem_rvld && sel_accum;
    assign fetch_bus.rdata = sel_accum ? '0 : mem_rdata;
    assign accum_bus.rdata = sel_accum ? mem_rdata : '0;

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            locked      <= 1'b0;
            owner_accum <= 1'b0;
        end else if (locked) begin
            if (mem_rvld) begin
                locked <= 1'b0;                // released on the ack
            end
        end else if (mem_req && !mem_rvld) begin
            locked      <= 1'b1;
            owner_accum <= sel_accum;
        end
    end

endmodule

/* hw/operand_fetch.sv */
`timescale 1ns/100ps

module operand_fetch (
    input  logic          I_CLK,
    input  logic          I_RST_N,
    fetch_if.fetcher      fet,
    tile_mem_if.requester mem
);
    import attn_pkg::*;

    tile_t rd_t;                               // read tile, transposed

    // read only port
    assign mem.we    = 1'b0;
    assign mem.wdata = '0;

    always_comb begin
        for (int r = 0; r < TILE_N; r++) begin
            for (int c = 0; c < TILE_N; c++) begin
                rd_t[r][c] = mem.rdata[c][r];
            end
        end
    end

    ////////////////////////////////////////
    // request level and ready pulse
    ////////////////////////////////////////
    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            mem.req   <= 1'b0;
            fet.ready <= 1'b0;
        end else begin
            fet.ready <= mem.rvld;             // tile lands with it
            if (fet.fetch) begin
                mem.req <= 1'b1;
            end else if (mem.rvld) begin
                mem.req <= 1'b0;
            end
        end
    end

    always_ff @(posedge I_CLK) begin
        if (fet.fetch) begin
            mem.kind <= fet.kind;
            mem.row  <= fet.row;
            mem.col  <= fet.col;
        end
        if (mem.rvld) begin
            fet.tile <= (mem.kind == KIND_K) ? rd_t : mem.rdata;
        end
    end

endmodule

/* hw/o_accum.sv */
`timescale 1ns/100ps

module o_accum (
    input  logic          I_CLK,
    input  logic          I_RST_N,
    accum_if.accum        acc,
    tile_mem_if.requester mem
);
    import attn_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE
    } state_e;

    state_e state;
    tile_t  res_q;                             // posted result tile
    tile_t  sum;

    assign mem.kind = KIND_O;
    assign mem.we   = (state == WRITE);

    // element-wise add, wraps mod 2^16
    always_comb begin
        for (int r = 0; r < TILE_N; r++) begin
            for (int c = 0; c < TILE_N; c++) begin
                sum[r][c] = res_q[r][c] + mem.rdata[r][c];
            end
        end
    end

    ////////////////////////////////////////
    // read-modify-write sequence
    ////////////////////////////////////////
    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            state    <= IDLE;
            acc.busy <= 1'b0;
            mem.req  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (acc.post) begin
                        acc.busy <= 1'b1;
                        mem.req  <= 1'b1;      // read old O
                        state    <= READ;
                    end
                end
                READ: begin
                    if (mem.rvld) begin
                        mem.req <= 1'b0;       // drop for one cycle
                        state   <= WRITE;
                    end
                end
                WRITE: begin
                    if (mem.rvld) begin
                        mem.req  <= 1'b0;
                        acc.busy <= 1'b0;
                        state    <= IDLE;
                    end else begin
                        mem.req <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge I_CLK) begin
        if (state == IDLE && acc.post) begin
            res_q   <= acc.tile;
            mem.row <= acc.row;
            mem.col <= acc.col;
        end
        if (state == READ && mem.rvld) begin
            mem.wdata <= sum;
        end
    end

endmodule

/* hw/attn_ctrl.sv */
`timescale 1ns/100ps

module attn_ctrl #(
    parameter int N_Q_TILES   = 2,
    parameter int N_KV_TILES  = 2,
    parameter int N_DBLK      = 2,
    parameter int SCALE_VALUE = 3
) (
    input  logic            I_CLK,
    input  logic            I_RST_N,
    input  logic            attn_start,
    output logic            attn_done,
    input  logic            sa_vld,
    input  attn_pkg::tile_t sa_result,
    output logic            sa_load,
    output logic            sa_acc,
    output attn_pkg::tile_t sa_mat_1,
    output attn_pkg::tile_t sa_mat_2,
    fetch_if.ctrl           fet,
    accum_if.ctrl           acc
);
    import attn_pkg::*;

    typedef enum logic [3:0] {
        IDLE, FETCH_Q, FETCH_K, QK, SCALE, FETCH_V, PV, POST, FINISH
    } state_e;

    state_e   state;
    row_idx_t kv_cnt;                          // outer loop
    row_idx_t q_cnt;                           // inner loop
    col_idx_t c_cnt;                           // depth block
    tile_t    res_q;                           // result waiting for post
    tile_t    diag_tile;
    logic     last_c;
    logic     last_q;
    logic     last_kv;

    assign last_c  = (c_cnt == col_idx_t'(N_DBLK - 1));
    assign last_q  = (q_cnt == row_idx_t'(N_Q_TILES - 1));
    assign last_kv = (kv_cnt == row_idx_t'(N_KV_TILES - 1));

    assign acc.post  = (state == POST) && !acc.busy;
    assign acc.row   = q_cnt;
    assign acc.col   = c_cnt;
    assign acc.tile  = res_q;
    assign attn_done = (state == FINISH) && !acc.busy;  // cycle after last ack

    always_comb begin
        diag_tile = '0;
        for (int i = 0; i < TILE_N; i++) begin
            diag_tile[i][i] = elem_t'(SCALE_VALUE);
        end
    end

    task automatic issue_fetch(input tile_kind_e kind, input row_idx_t row,
                               input col_idx_t col);
        fet.fetch <= 1'b1;
        fet.kind  <= kind;
        fet.row   <= row;
        fet.col   <= col;
    endtask

    ////////////////////////////////////////
    // tile loop sequencer
    ////////////////////////////////////////
    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            state     <= IDLE;
            kv_cnt    <= '0;
            q_cnt     <= '0;
            c_cnt     <= '0;
            sa_load   <= 1'b0;
            sa_acc    <= 1'b0;
            fet.fetch <= 1'b0;
            fet.kind  <= KIND_Q;
            fet.row   <= '0;
            fet.col   <= '0;
        end else begin
            sa_load   <= 1'b0;
            fet.fetch <= 1'b0;
            case (state)
                IDLE: begin
                    if (attn_start) begin
                        kv_cnt <= '0;
                        q_cnt  <= '0;
                        c_cnt  <= '0;
                        issue_fetch(KIND_Q, '0, '0);
                        state  <= FETCH_Q;
                    end
                end
                FETCH_Q: begin
                    if (fet.ready) begin
                        issue_fetch(KIND_K, kv_cnt, c_cnt);
                        state <= FETCH_K;
                    end
                end
                FETCH_K: begin
                    if (fet.ready) begin
                        sa_load <= 1'b1;
                        sa_acc  <= (c_cnt != '0);  // sum over depth blocks
                        state   <= QK;
                    end
                end
                QK: begin
                    if (sa_vld && last_c) begin
                        sa_load <= 1'b1;       // S times diag
                        sa_acc  <= 1'b0;
                        c_cnt   <= '0;
                        state   <= SCALE;
                    end else if (sa_vld) begin
                        c_cnt <= c_cnt + 1'b1;
                        issue_fetch(KIND_Q, q_cnt, c_cnt + 1'b1);
                        state <= FETCH_Q;
                    end
                end
                SCALE: begin
                    if (sa_vld) begin
                        issue_fetch(KIND_V, kv_cnt, '0);
                        state <= FETCH_V;
                    end
                end
                FETCH_V: begin
                    if (fet.ready) begin
                        sa_load <= 1'b1;
                        sa_acc  <= 1'b0;
                        state   <= PV;
                    end
                end
                PV: begin
                    if (sa_vld) begin
                        state <= POST;
                    end
                end
                POST: begin
                    if (!acc.busy) begin
                        if (!last_c) begin
                            c_cnt <= c_cnt + 1'b1;
                            issue_fetch(KIND_V, kv_cnt, c_cnt + 1'b1);
                            state <= FETCH_V;
                        end else if (last_q && last_kv) begin
                            state <= FINISH;
                        end else if (last_q) begin
                            c_cnt  <= '0;
                            q_cnt  <= '0;
                            kv_cnt <= kv_cnt + 1'b1;
                            issue_fetch(KIND_Q, '0, '0);
                            state  <= FETCH_Q;
                        end else begin
                            c_cnt <= '0;
                            q_cnt <= q_cnt + 1'b1;
                            issue_fetch(KIND_Q, q_cnt + 1'b1, '0);
                            state <= FETCH_Q;
                        end
                    end
                end
                FINISH: begin
                    if (!acc.busy) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // sa_mat_1 keeps the scaled scores through all PV loads
    always_ff @(posedge I_CLK) begin
        if (state == FETCH_Q && fet.ready) begin
            sa_mat_1 <= fet.tile;
        end else if ((state == QK && last_c && sa_vld) || (state == SCALE && sa_vld)) begin
            sa_mat_1 <= sa_result;
        end
        if ((state == FETCH_K || state == FETCH_V) && fet.ready) begin
            sa_mat_2 <= fet.tile;
        end else if (state == QK && last_c && sa_vld) begin
            sa_mat_2 <= diag_tile;
        end
        if (state == PV && sa_vld) begin
            res_q <= sa_result;
        end
    end

endmodule

/* hw/attn_top.sv */
`timescale 1ns/100ps

module attn_top #(
    parameter int N_Q_TILES   = 2,
    parameter int N_KV_TILES  = 2,
    parameter int N_DBLK      = 2,
    parameter int SCALE_VALUE = 3
) (
    input  logic                 I_CLK,
    input  logic                 I_RST_N,
    input  logic                 attn_start,
    output logic                 attn_done,
    output logic                 mem_req,
    output logic                 mem_we,
    output attn_pkg::tile_kind_e mem_kind,
    output attn_pkg::row_idx_t   mem_row,
    output attn_pkg::col_idx_t   mem_col,
    output attn_pkg::tile_t      mem_wdata,
    input  attn_pkg::tile_t      mem_rdata,
    input  logic                 mem_rvld,
    output logic                 sa_load,
    output logic                 sa_acc,
    output attn_pkg::tile_t      sa_mat_1,
    output attn_pkg::tile_t      sa_mat_2,
    input  logic                 sa_vld,
    input  attn_pkg::tile_t      sa_result
);

    fetch_if    fetch_bus ();
    accum_if    accum_bus ();
    tile_mem_if fetch_mem ();                  // fetcher side of the arbiter
    tile_mem_if accum_mem ();                  // accumulator side

    attn_ctrl #(
        .N_Q_TILES   (N_Q_TILES),
        .N_KV_TILES  (N_KV_TILES),
        .N_DBLK      (N_DBLK),
        .SCALE_VALUE (SCALE_VALUE)
    ) u_ctrl (
        .I_CLK      (I_CLK),
        .I_RST_N    (I_RST_N),
        .attn_start (attn_start),
        .attn_done  (attn_done),
        .sa_vld     (sa_vld),
        .sa_result  (sa_result),
        .sa_load    (sa_load),
        .sa_acc     (sa_acc),
        .sa_mat_1   (sa_mat_1),
        .sa_mat_2   (sa_mat_2),
        .fet        (fetch_bus),
        .acc        (accum_bus)
    );

    operand_fetch u_fetch (
        .I_CLK   (I_CLK),
        .I_RST_N (I_RST_N),
        .fet     (fetch_bus),
        .mem     (fetch_mem)
    );

    o_accum u_accum (
        .I_CLK   (I_CLK),
        .I_RST_N (I_RST_N),
        .acc     (accum_bus),
        .mem     (accum_mem)
    );

    tile_arbiter u_arb (
        .I_CLK     (I_CLK),
        .I_RST_N   (I_RST_N),
        .fetch_bus (fetch_mem),
        .accum_bus (accum_mem),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_kind  (mem_kind),
        .mem_row   (mem_row),
        .mem_col   (mem_col),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_rvld  (mem_rvld)
    );

endmodule

/* tests/tb_attn.sv */
`timescale 1ns/100ps

module tb_attn;
    import attn_pkg::*;

    localparam int N_Q_TILES   = 2;
    localparam int N_KV_TILES  = 2;
    localparam int N_DBLK      = 2;
    localparam int SCALE_VALUE = 3;
    localparam int N_CASES     = 5;
    localparam int LOADS       = N_CASES * N_KV_TILES * N_Q_TILES * (2 * N_DBLK + 1);
    localparam int WATCHDOG_CYCLES = 200 * LOADS + 16;

    typedef logic [$bits(tile_t)-1:0] word_t;
    typedef enum logic [1:0] {FILL_ZERO, FILL_IDENT, FILL_RAND} fill_e;
    typedef struct packed {
        fill_e q;
        fill_e k;
        fill_e v;
        fill_e o;
        logic  restart;                        // second start mid-run
    } case_t;

    // q, k, v, o fill and restart flag per case
    case_t case_table [N_CASES] = '{
        '{FILL_RAND,  FILL_RAND,  FILL_RAND,  FILL_RAND, 1'b0},
        '{FILL_RAND,  FILL_ZERO,  FILL_RAND,  FILL_RAND, 1'b0},
        '{FILL_IDENT, FILL_IDENT, FILL_RAND,  FILL_RAND, 1'b0},
        '{FILL_RAND,  FILL_RAND,  FILL_RAND,  FILL_RAND, 1'b1},
        '{FILL_IDENT, FILL_IDENT, FILL_IDENT, FILL_ZERO, 1'b0}
    };

    logic       I_CLK;
    logic       I_RST_N;
    logic       attn_start;
    logic       attn_done;
    logic       mem_req;
    logic       mem_we;
    tile_kind_e mem_kind;
    row_idx_t   mem_row;
    col_idx_t   mem_col;
    tile_t      mem_wdata;
    tile_t      mem_rdata;
    logic       mem_rvld;
    logic       sa_load;
    logic       sa_acc;
    tile_t      sa_mat_1;
    tile_t      sa_mat_2;
    logic       sa_vld;
    tile_t      sa_result;

    tile_t mem_store [int];                    // tile memory contents
    tile_t exp_store [int];                    // expected contents
    int    done_cnt = 0;

    attn_top #(
        .N_Q_TILES   (N_Q_TILES),
        .N_KV_TILES  (N_KV_TILES),
        .N_DBLK      (N_DBLK),
        .SCALE_VALUE (SCALE_VALUE)
    ) dut (
        .I_CLK      (I_CLK),
        .I_RST_N    (I_RST_N),
        .attn_start (attn_start),
        .attn_done  (attn_done),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_kind   (mem_kind),
        .mem_row    (mem_row),
        .mem_col    (mem_col),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_rvld   (mem_rvld),
        .sa_load    (sa_load),
        .sa_acc     (sa_acc),
        .sa_mat_1   (sa_mat_1),
        .sa_mat_2   (sa_mat_2),
        .sa_vld     (sa_vld),
        .sa_result  (sa_result)
    );

    initial begin
        I_CLK = 1'b0;
        forever #5 I_CLK = ~I_CLK;
    end

    always @(negedge I_CLK) begin
        if (attn_done) begin
            done_cnt = done_cnt + 1;
        end
    end

    ////////////////////////////////////////
    // checks and tile arithmetic
    ////////////////////////////////////////
    task automatic check_eq(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic verify_idle_outputs();
        check_eq("attn_done", word_t'(attn_done), '0);
        check_eq("sa_load", word_t'(sa_load), '0);
        check_eq("mem_req", word_t'(mem_req), '0);
    endtask

    function automatic int key_of(input tile_kind_e kind, input int row, input int col);
        return int'(kind) * 4096 + row * 64 + col;
    endfunction

    function automatic tile_t mat_mul(input tile_t a, input tile_t b);
        tile_t p;
        p = '0;
        for (int i = 0; i < TILE_N; i++) begin
            for (int j = 0; j < TILE_N; j++) begin
                for (int k = 0; k < TILE_N; k++) begin
                    p[i][j] = p[i][j] + a[i][k] * b[k][j];  // wraps mod 2^16
                end
            end
        end
        return p;
    endfunction

    function automatic tile_t mat_add(input tile_t a, input tile_t b);
        tile_t s;
        for (int i = 0; i < TILE_N; i++) begin
            for (int j = 0; j < TILE_N; j++) begin
                s[i][j] = a[i][j] + b[i][j];
            end
        end
        return s;
    endfunction

    function automatic tile_t transpose(input tile_t a);
        tile_t t;
        for (int i = 0; i < TILE_N; i++) begin
            for (int j = 0; j < TILE_N; j++) begin
                t[i][j] = a[j][i];
            end
        end
        return t;
    endfunction

    function automatic tile_t scale_tile(input tile_t a);
        tile_t t;
        for (int i = 0; i < TILE_N; i++) begin
            for (int j = 0; j < TILE_N; j++) begin
                t[i][j] = a[i][j] * elem_t'(SCALE_VALUE);
            end
        end
        return t;
    endfunction

    function automatic tile_t fill_tile(input fill_e mode);
        tile_t t;
        t = '0;
        for (int i = 0; i < TILE_N; i++) begin
            for (int j = 0; j < TILE_N; j++) begin
                if (mode == FILL_RAND) begin
                    t[i][j] = elem_t'($urandom);
                end else if (mode == FILL_IDENT && i == j) begin
                    t[i][j] = elem_t'(1);
                end
            end
        end
        return t;
    endfunction

    ////////////////////////////////////////
    // memory model, 1 to 4 cycles per access
    ////////////////////////////////////////
    initial begin : memory_model
        logic  pending;
        logic  wr;
        int    wait_n;
        int    key;
        tile_t wd;
        mem_rvld  = 1'b0;
        mem_rdata = '0;
        pending   = 1'b0;
        forever begin
            @(posedge I_CLK);
            #1;
            mem_rvld = 1'b0;
            if (pending) begin
                if (wait_n == 0) begin
                    pending  = 1'b0;
                    mem_rvld = 1'b1;
                    if (wr) begin
                        mem_store[key] = wd;
                    end else begin
                        mem_rdata = mem_store.exists(key) ? mem_store[key] : '0;
                    end
                end else begin
                    wait_n--;
                end
            end else if (mem_req) begin
                if (mem_we) begin
                    check_eq("mem_kind on write", word_t'(mem_kind), word_t'(KIND_O));
                end
                pending = 1'b1;
                wr      = mem_we;
                wd      = mem_wdata;
                key     = key_of(mem_kind, int'(mem_row), int'(mem_col));
                wait_n  = $urandom_range(0, 3);
            end
        end
    end

    ////////////////////////////////////////
    // systolic array model, 2 to 6 cycles
    ////////////////////////////////////////
    initial begin : array_model
        logic  pending;
        int    wait_n;
        tile_t prod;
        tile_t last;
        sa_vld    = 1'b0;
        sa_result = '0;
        pending   = 1'b0;
        last      = '0;
        forever begin
            @(posedge I_CLK);
            #1;
            sa_vld = 1'b0;
            if (pending) begin
                check_eq("sa_load while busy", word_t'(sa_load), '0);
                if (wait_n == 0) begin
                    pending   = 1'b0;
                    sa_vld    = 1'b1;
                    sa_result = prod;
                end else begin
                    wait_n--;
                end
            end else if (sa_load) begin
                prod = mat_mul(sa_mat_1, sa_mat_2);
                if (sa_acc) begin
                    prod = mat_add(prod, last);  // adds to previous result
                end
                last    = prod;
                pending = 1'b1;
                wait_n  = $urandom_range(1, 5);
            end
        end
    end

    // fills memory and runs the loop order in software
    task automatic load_case(input case_t tc);
        tile_t s;
        tile_t p;
        mem_store.delete();
        for (int r = 0; r < N_Q_TILES; r++) begin
            for (int c = 0; c < N_DBLK; c++) begin
                mem_store[key_of(KIND_Q, r, c)] = fill_tile(tc.q);
                mem_store[key_of(KIND_O, r, c)] = fill_tile(tc.o);
            end
        end
        for (int r = 0; r < N_KV_TILES; r++) begin
            for (int c = 0; c < N_DBLK; c++) begin
                mem_store[key_of(KIND_K, r, c)] = fill_tile(tc.k);
                mem_store[key_of(KIND_V, r, c)] = fill_tile(tc.v);
            end
        end
        exp_store = mem_store;
        for (int kv = 0; kv < N_KV_TILES; kv++) begin
            for (int q = 0; q < N_Q_TILES; q++) begin
                s = '0;
                for (int c = 0; c < N_DBLK; c++) begin
                    s = mat_add(s, mat_mul(exp_store[key_of(KIND_Q, q, c)],
                                           transpose(exp_store[key_of(KIND_K, kv, c)])));
                end
                p = scale_tile(s);
                for (int c = 0; c < N_DBLK; c++) begin
                    exp_store[key_of(KIND_O, q, c)] = mat_add(exp_store[key_of(KIND_O, q, c)],
                        mat_mul(p, exp_store[key_of(KIND_V, kv, c)]));
                end
            end
        end
    endtask

    task automatic run_case(input int idx, input case_t tc);
        int base;
        load_case(tc);
        base = done_cnt;
        @(posedge I_CLK);
        #1 attn_start = 1'b1;
        @(posedge I_CLK);
        #1 attn_start = 1'b0;
        if (tc.restart) begin
            repeat (30) @(posedge I_CLK);
            #1;
            check_eq("attn_done before restart", word_t'(done_cnt - base), '0);
            attn_start = 1'b1;
            @(posedge I_CLK);
            #1 attn_start = 1'b0;
        end
        while (done_cnt == base) begin
            @(posedge I_CLK);
        end
        repeat (20) @(posedge I_CLK);
        check_eq($sformatf("case %0d attn_done pulses", idx), word_t'(done_cnt - base),
                 word_t'(1));
        foreach (exp_store[k]) begin
            check_eq($sformatf("case %0d tile kind %0d row %0d col %0d", idx, k / 4096,
                               (k / 64) % 64, k % 64), mem_store[k], exp_store[k]);
        end
    endtask

    initial begin : main
        void'($urandom(24));
        I_RST_N    = 1'b0;
        attn_start = 1'b0;
        repeat (16) begin
            @(negedge I_CLK);
            verify_idle_outputs();
        end
        @(posedge I_CLK);
        #1 I_RST_N = 1'b1;
        repeat (4) begin
            @(negedge I_CLK);
            verify_idle_outputs();             // still quiet without start
        end
        for (int i = 0; i < N_CASES; i++) begin
            run_case(i, case_table[i]);
        end
        $display("Result: PASSED");
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge I_CLK);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* tb.f */
hw/attn_pkg.sv
hw/attn_ifs.sv
hw/tile_arbiter.sv
hw/operand_fetch.sv
hw/o_accum.sv
hw/attn_ctrl.sv
hw/attn_top.sv
tests/tb_attn.sv

/* Makefile */
# Verilator build and run of the attention engine testbench

VERILATOR ?= verilator
TOP       := tb_attn
FILELIST  := tb.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0 --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
